// ==== common/rv_core_pkg.sv ====
// ========================================
// shared widths and types for the core
// opcode and ALU operation enums
// funct3 / funct7 field constants
// ========================================

package rv_core_pkg;

    localparam int XLEN = 32;

    // pc advances one word per instruction
    localparam int INST_BYTES = 4;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes the core executes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } alu_op_e;

    // funct3 for OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for branches and stores
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    // funct7 selects SUB over ADD
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // addi x0, x0, 0
    localparam word_t NOP_INST = 32'h0000_0013;

endpackage

// ==== fetch/fetch_unit.sv ====
// ========================================
// fetch unit: program counter, request
// issue under queue back-pressure and
// capture of the one-cycle response
// ========================================

`timescale 1ns/10ps

module fetch_unit #(
    parameter int                 QUEUE_DEPTH = 4,
    parameter rv_core_pkg::word_t RESET_PC    = '0,
    localparam int                LVL_W       = $clog2(QUEUE_DEPTH) + 1
) (
    input  logic               clk,
    input  logic               rst_i,
    input  logic [LVL_W-1:0]   level_i,
    input  logic               redirect_i,
    input  rv_core_pkg::word_t redirect_pc_i,
    output logic               imem_req_o,
    output rv_core_pkg::word_t imem_addr_o,
    input  rv_core_pkg::word_t imem_rdata_i,
    output logic               push_o,
    output rv_core_pkg::word_t push_inst_o,
    output rv_core_pkg::word_t push_pc_o
);

    rv_core_pkg::word_t pc_q;
    rv_core_pkg::word_t inflight_pc_q;
    logic               inflight_q;
    logic               kill_q;
    logic [LVL_W:0]     fill_cnt;
    logic               issue;

    // queue entries plus the response still on its way
    assign fill_cnt = {1'b0, level_i} + (LVL_W+1)'(inflight_q);

    // idle in reset and whenever a push could meet a full queue
    assign issue = !rst_i && (fill_cnt < (LVL_W+1)'(QUEUE_DEPTH));

    assign imem_req_o  = issue;
    assign imem_addr_o = pc_q;

    // a response overtaken by a redirect is dropped
    assign push_o      = inflight_q && !kill_q && !redirect_i;
    assign push_inst_o = imem_rdata_i;
    assign push_pc_o   = inflight_pc_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q       <= RESET_PC;
            inflight_q <= 1'b0;
            kill_q     <= 1'b0;
        end else begin
            inflight_q <= issue;
            // request issued alongside a redirect is from the wrong path
            kill_q     <= issue && redirect_i;
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (issue) begin
                pc_q <= pc_q + rv_core_pkg::word_t'(rv_core_pkg::INST_BYTES);
            end
        end
    end

    // pc of the outstanding request, paired with its response
    always_ff @(posedge clk) begin
        if (issue) begin
            inflight_pc_q <= pc_q;
        end
    end

    a_redirect_aligned: assert property (
        @(posedge clk) disable iff (rst_i)
        redirect_i |-> (redirect_pc_i[1:0] == 2'b00)
    ) else $error("fetch redirect to unaligned pc %h", redirect_pc_i);

endmodule

// ==== source/inst_queue.sv ====
// ========================================
// instruction queue: circular buffer of
// instruction / pc pairs with flush
// ========================================

`timescale 1ns/10ps

module inst_queue #(
    parameter int  QUEUE_DEPTH = 4,
    localparam int PTR_W       = $clog2(QUEUE_DEPTH),
    localparam int LVL_W       = $clog2(QUEUE_DEPTH) + 1
) (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               flush_i,
    input  logic               push_i,
    input  rv_core_pkg::word_t push_inst_i,
    input  rv_core_pkg::word_t push_pc_i,
    input  logic               pop_i,
    output logic               not_empty_o,
    output logic [LVL_W-1:0]   level_o,
    output rv_core_pkg::word_t head_inst_o,
    output rv_core_pkg::word_t head_pc_o
);

    rv_core_pkg::word_t inst_mem [QUEUE_DEPTH];
    rv_core_pkg::word_t pc_mem   [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [LVL_W-1:0]   count_q;
    logic               full;
    logic               do_push;
    logic               do_pop;

    assign full        = (count_q == LVL_W'(QUEUE_DEPTH));
    assign not_empty_o = (count_q != '0);
    assign level_o     = count_q;

    assign do_push = push_i && !flush_i;
    assign do_pop  = pop_i && not_empty_o && !flush_i;

    // empty queue presents a no-op at the head
    assign head_inst_o = not_empty_o ? inst_mem[rd_ptr_q] : rv_core_pkg::NOP_INST;
    assign head_pc_o   = pc_mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            inst_mem[wr_ptr_q] <= push_inst_i;
            pc_mem[wr_ptr_q]   <= push_pc_i;
        end
    end

    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst_i) push_i |-> !full
    ) else $error("push into full instruction queue");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst_i) pop_i |-> not_empty_o
    ) else $error("pop from empty instruction queue");

endmodule

// ==== execute/reg_file.sv ====
// ========================================
// register file: x1..x31, x0 reads zero
// two read ports, one write port
// ========================================

`timescale 1ns/10ps

module reg_file (
    input  logic                   clk,
    input  logic                   rst_i,
    input  rv_core_pkg::reg_addr_t rs1_i,
    input  rv_core_pkg::reg_addr_t rs2_i,
    output rv_core_pkg::word_t     rs1_data_o,
    output rv_core_pkg::word_t     rs2_data_o,
    input  logic                   we_i,
    input  rv_core_pkg::reg_addr_t rd_i,
    input  rv_core_pkg::word_t     rd_data_i
);

    // no storage for x0
    rv_core_pkg::word_t regs_q [1:31];

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin
            regs_q[rd_i] <= rd_data_i;
        end
    end

endmodule

// ==== execute/exec_core.sv ====
// ========================================
// execute core: decode, ALU, branch and
// jump resolution, writeback, store strobe
// ========================================

`timescale 1ns/10ps

module exec_core (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               valid_i,
    input  rv_core_pkg::word_t inst_i,
    input  rv_core_pkg::word_t pc_i,
    output logic               pop_o,
    output logic               redirect_o,
    output rv_core_pkg::word_t redirect_pc_o,
    output logic               dmem_we_o,
    output rv_core_pkg::word_t dmem_addr_o,
    output rv_core_pkg::word_t dmem_wdata_o
);

    rv_core_pkg::opcode_e   opcode;
    rv_core_pkg::alu_op_e   alu_op;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    rv_core_pkg::reg_addr_t rd;
    rv_core_pkg::word_t     rs1_data;
    rv_core_pkg::word_t     rs2_data;
    rv_core_pkg::word_t     imm_i;
    rv_core_pkg::word_t     imm_s;
    rv_core_pkg::word_t     imm_b;
    rv_core_pkg::word_t     imm_j;
    rv_core_pkg::word_t     imm_u;
    rv_core_pkg::word_t     alu_b;
    rv_core_pkg::word_t     alu_result;
    rv_core_pkg::word_t     link_pc;
    rv_core_pkg::word_t     rd_data;
    logic                   use_imm;
    logic                   is_alu;
    logic                   is_lui;
    logic                   is_jal;
    logic                   is_branch;
    logic                   is_sw;
    logic                   br_taken;
    logic                   rd_we;

    assign opcode = rv_core_pkg::opcode_e'(inst_i[6:0]);
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // immediate formats
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};

    reg_file u_reg_file (
        .clk        (clk),
        .rst_i      (rst_i),
        .rs1_i      (inst_i[19:15]),
        .rs2_i      (inst_i[24:20]),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rd_we),
        .rd_i       (rd),
        .rd_data_i  (rd_data)
    );

    // anything not matched here retires as a no-op
    always_comb begin
        alu_op    = rv_core_pkg::ALU_ADD;
        use_imm   = 1'b0;
        is_alu    = 1'b0;
        is_lui    = 1'b0;
        is_jal    = 1'b0;
        is_branch = 1'b0;
        is_sw     = 1'b0;
        case (opcode)
            rv_core_pkg::OPC_OP: begin
                is_alu = (funct7 == rv_core_pkg::F7_BASE) ||
                         ((funct7 == rv_core_pkg::F7_ALT) &&
                          (funct3 == rv_core_pkg::F3_ADD_SUB));
                case (funct3)
                    rv_core_pkg::F3_ADD_SUB: alu_op = (funct7 == rv_core_pkg::F7_ALT) ?
                                                      rv_core_pkg::ALU_SUB :
                                                      rv_core_pkg::ALU_ADD;
                    rv_core_pkg::F3_SLL: alu_op = rv_core_pkg::ALU_SLL;
                    rv_core_pkg::F3_SLT: alu_op = rv_core_pkg::ALU_SLT;
                    rv_core_pkg::F3_XOR: alu_op = rv_core_pkg::ALU_XOR;
                    rv_core_pkg::F3_SRL: alu_op = rv_core_pkg::ALU_SRL;
                    rv_core_pkg::F3_OR:  alu_op = rv_core_pkg::ALU_OR;
                    rv_core_pkg::F3_AND: alu_op = rv_core_pkg::ALU_AND;
                    default: is_alu = 1'b0;
                endcase
            end
            rv_core_pkg::OPC_OP_IMM: begin
                use_imm = 1'b1;
                is_alu  = 1'b1;
                case (funct3)
                    rv_core_pkg::F3_ADD_SUB: alu_op = rv_core_pkg::ALU_ADD;
                    rv_core_pkg::F3_XOR:     alu_op = rv_core_pkg::ALU_XOR;
                    rv_core_pkg::F3_OR:      alu_op = rv_core_pkg::ALU_OR;
                    rv_core_pkg::F3_AND:     alu_op = rv_core_pkg::ALU_AND;
                    default: is_alu = 1'b0;
                endcase
            end
            rv_core_pkg::OPC_LUI:    is_lui = 1'b1;
            rv_core_pkg::OPC_JAL:    is_jal = 1'b1;
            rv_core_pkg::OPC_BRANCH: is_branch = (funct3 == rv_core_pkg::F3_BEQ) ||
                                                 (funct3 == rv_core_pkg::F3_BNE);
            // only full-word stores
            rv_core_pkg::OPC_STORE:  is_sw = (funct3 == rv_core_pkg::F3_SW);
            default: ;
        endcase
    end

    assign alu_b = use_imm ? imm_i : rs2_data;

    always_comb begin
        case (alu_op)
            rv_core_pkg::ALU_ADD: alu_result = rs1_data + alu_b;
            rv_core_pkg::ALU_SUB: alu_result = rs1_data - alu_b;
            rv_core_pkg::ALU_AND: alu_result = rs1_data & alu_b;
            rv_core_pkg::ALU_OR:  alu_result = rs1_data | alu_b;
            rv_core_pkg::ALU_XOR: alu_result = rs1_data ^ alu_b;
            rv_core_pkg::ALU_SLT: alu_result = {31'b0, $signed(rs1_data) < $signed(alu_b)};
            rv_core_pkg::ALU_SLL: alu_result = rs1_data << alu_b[4:0];
            rv_core_pkg::ALU_SRL: alu_result = rs1_data >> alu_b[4:0];
            default:              alu_result = '0;
        endcase
    end

    // BNE inverts the equality test
    assign br_taken = is_branch &&
                      ((rs1_data == rs2_data) ^ (funct3 == rv_core_pkg::F3_BNE));

    assign link_pc = pc_i + rv_core_pkg::word_t'(rv_core_pkg::INST_BYTES);

    assign rd_data = is_lui ? imm_u :
                     is_jal ? link_pc : alu_result;
    assign rd_we   = valid_i && (is_alu || is_lui || is_jal);

    // the head retires every cycle it is present
    assign pop_o         = valid_i;
    assign redirect_o    = valid_i && (is_jal || br_taken);
    assign redirect_pc_o = pc_i + (is_jal ? imm_j : imm_b);

    assign dmem_we_o    = valid_i && is_sw;
    assign dmem_addr_o  = rs1_data + imm_s;
    assign dmem_wdata_o = rs2_data;

    a_store_valid: assert property (
        @(posedge clk) disable iff (rst_i) dmem_we_o |-> valid_i
    ) else $error("store strobe without a valid instruction");

    // flush leaves nothing to retire on the wrong path
    a_redirect_drains: assert property (
        @(posedge clk) disable iff (rst_i) redirect_o |=> !valid_i
    ) else $error("instruction retired right after a redirect");

endmodule

// ==== source/rv_core_top.sv ====
// ========================================
// core top level: fetch, instruction
// queue and execute wired together
// ========================================

`timescale 1ns/10ps

module rv_core_top #(
    parameter int                 QUEUE_DEPTH = 4,
    parameter rv_core_pkg::word_t RESET_PC    = '0
) (
    input  logic               clk,
    input  logic               rst_i,
    output logic               imem_req_o,
    output rv_core_pkg::word_t imem_addr_o,
    input  rv_core_pkg::word_t imem_rdata_i,
    output logic               dmem_we_o,
    output rv_core_pkg::word_t dmem_addr_o,
    output rv_core_pkg::word_t dmem_wdata_o
);

    localparam int LVL_W = $clog2(QUEUE_DEPTH) + 1;

    // fetch to queue
    logic               push;
    rv_core_pkg::word_t push_inst;
    rv_core_pkg::word_t push_pc;
    logic [LVL_W-1:0]   level;

    // queue to execute
    logic               not_empty;
    rv_core_pkg::word_t head_inst;
    rv_core_pkg::word_t head_pc;
    logic               pop;

    // taken branch or jump
    logic               redirect;
    rv_core_pkg::word_t redirect_pc;

    fetch_unit #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .RESET_PC    (RESET_PC)
    ) u_fetch_unit (
        .clk           (clk),
        .rst_i         (rst_i),
        .level_i       (level),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .imem_rdata_i  (imem_rdata_i),
        .push_o        (push),
        .push_inst_o   (push_inst),
        .push_pc_o     (push_pc)
    );

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_inst_queue (
        .clk         (clk),
        .rst_i       (rst_i),
        .flush_i     (redirect),
        .push_i      (push),
        .push_inst_i (push_inst),
        .push_pc_i   (push_pc),
        .pop_i       (pop),
        .not_empty_o (not_empty),
        .level_o     (level),
        .head_inst_o (head_inst),
        .head_pc_o   (head_pc)
    );

    exec_core u_exec_core (
        .clk           (clk),
        .rst_i         (rst_i),
        .valid_i       (not_empty),
        .inst_i        (head_inst),
        .pc_i          (head_pc),
        .pop_o         (pop),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .dmem_we_o     (dmem_we_o),
        .dmem_addr_o   (dmem_addr_o),
        .dmem_wdata_o  (dmem_wdata_o)
    );

endmodule

// ==== tb/tb_programs.svh ====
// ========================================
// RV32I instruction encoders and the
// directed test programs with their
// expected stores
// ========================================

`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

function automatic rv_core_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic rv_core_pkg::word_t enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic rv_core_pkg::word_t enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
endfunction

function automatic rv_core_pkg::word_t enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                              input int off);
    logic [11:0] o;
    o = 12'(off);
    return {o[11:5], rs2, rs1, 3'b010, o[4:0], 7'b0100011};
endfunction

function automatic rv_core_pkg::word_t enc_br(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input int off);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'b1100011};
endfunction

function automatic rv_core_pkg::word_t enc_jal(input logic [4:0] rd, input int off);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], rd, 7'b1101111};
endfunction

// lui plus addi, upper part rounded for the signed low half
task automatic load_const(input logic [4:0] rd, input rv_core_pkg::word_t value);
    rv_core_pkg::word_t upper;
    upper = value + 32'h0000_0800;
    emit(enc_lui(rd, upper[31:12]));
    emit(enc_i(3'b000, rd, rd, value[11:0]));
endtask

// result lands in x4 and is stored at off(x3)
task automatic op_and_store(input rv_core_pkg::word_t inst, input rv_core_pkg::word_t result,
                            input rv_core_pkg::word_t base, inout int off);
    emit(inst);
    emit(enc_sw(5'd4, 5'd3, off));
    expect_store(base + rv_core_pkg::word_t'(off), result);
    off += 4;
endtask

task automatic test_alu();
    rv_core_pkg::word_t a;
    rv_core_pkg::word_t b;
    rv_core_pkg::word_t base;
    rv_core_pkg::word_t simm;
    logic [11:0]        imm;
    int                 off;
    begin_test("ALU register and immediate operations");
    for (int r = 0; r < 3; r++) begin
        a    = $urandom();
        b    = $urandom();
        base = $urandom() & 32'hffff_fffc;
        imm  = 12'($urandom());
        simm = {{20{imm[11]}}, imm};
        off  = 0;
        // first round puts a negative against a positive for SLT
        if (r == 0) begin
            a = a | 32'h8000_0000;
            b = b & 32'h7fff_ffff;
        end
        load_const(5'd1, a);
        load_const(5'd2, b);
        load_const(5'd3, base);
        op_and_store(enc_r(7'h00, 3'b000, 5'd4, 5'd1, 5'd2), a + b, base, off);
        op_and_store(enc_r(7'h20, 3'b000, 5'd4, 5'd1, 5'd2), a - b, base, off);
        op_and_store(enc_r(7'h00, 3'b111, 5'd4, 5'd1, 5'd2), a & b, base, off);
        op_and_store(enc_r(7'h00, 3'b110, 5'd4, 5'd1, 5'd2), a | b, base, off);
        op_and_store(enc_r(7'h00, 3'b100, 5'd4, 5'd1, 5'd2), a ^ b, base, off);
        op_and_store(enc_r(7'h00, 3'b010, 5'd4, 5'd1, 5'd2),
                     ($signed(a) < $signed(b)) ? 32'd1 : 32'd0, base, off);
        op_and_store(enc_r(7'h00, 3'b001, 5'd4, 5'd1, 5'd2), a << b[4:0], base, off);
        op_and_store(enc_r(7'h00, 3'b101, 5'd4, 5'd1, 5'd2), a >> b[4:0], base, off);
        op_and_store(enc_i(3'b000, 5'd4, 5'd1, imm), a + simm, base, off);
        op_and_store(enc_i(3'b111, 5'd4, 5'd1, imm), a & simm, base, off);
        op_and_store(enc_i(3'b110, 5'd4, 5'd1, imm), a | simm, base, off);
        op_and_store(enc_i(3'b100, 5'd4, 5'd1, imm), a ^ simm, base, off);
    end
    run_program();
endtask

task automatic test_x0_lui();
    logic [19:0] up;
    begin_test("x0 writes and LUI");
    up = 20'($urandom());
    emit(enc_i(3'b000, 5'd3, 5'd0, 12'h200));
    emit(enc_i(3'b000, 5'd0, 5'd0, 12'h5a5));
    emit(enc_sw(5'd0, 5'd3, 0));
    expect_store(32'h200, 32'h0);
    emit(enc_r(7'h00, 3'b000, 5'd0, 5'd3, 5'd3));
    emit(enc_sw(5'd0, 5'd3, 4));
    expect_store(32'h204, 32'h0);
    emit(enc_lui(5'd5, up));
    emit(enc_sw(5'd5, 5'd3, 8));
    expect_store(32'h208, {up, 12'h000});
    run_program();
endtask

task automatic test_branches();
    begin_test("BEQ and BNE taken and not taken");
    emit(enc_i(3'b000, 5'd3, 5'd0, 12'h300));
    emit(enc_i(3'b000, 5'd1, 5'd0, 12'd5));
    emit(enc_i(3'b000, 5'd2, 5'd0, 12'd5));
    emit(enc_i(3'b000, 5'd6, 5'd0, 12'd7));
    // beq taken over two stores
    emit(enc_br(3'b000, 5'd1, 5'd2, 12));
    emit(enc_sw(5'd1, 5'd3, 0));
    emit(enc_sw(5'd1, 5'd3, 4));
    emit(enc_sw(5'd2, 5'd3, 8));
    expect_store(32'h308, 32'd5);
    // beq not taken
    emit(enc_br(3'b000, 5'd1, 5'd6, 8));
    emit(enc_sw(5'd6, 5'd3, 12));
    expect_store(32'h30c, 32'd7);
    emit(enc_sw(5'd1, 5'd3, 16));
    expect_store(32'h310, 32'd5);
    // bne taken
    emit(enc_br(3'b001, 5'd1, 5'd6, 8));
    emit(enc_sw(5'd1, 5'd3, 20));
    emit(enc_sw(5'd6, 5'd3, 24));
    expect_store(32'h318, 32'd7);
    // bne not taken
    emit(enc_br(3'b001, 5'd1, 5'd2, 8));
    emit(enc_sw(5'd2, 5'd3, 28));
    expect_store(32'h31c, 32'd5);
    emit(enc_sw(5'd1, 5'd3, 32));
    expect_store(32'h320, 32'd5);
    run_program();
endtask

task automatic test_jal();
    rv_core_pkg::word_t jal_pc;
    begin_test("JAL link and skipped store");
    emit(enc_i(3'b000, 5'd3, 5'd0, 12'h400));
    jal_pc = next_pc();
    emit(enc_jal(5'd7, 8));
    emit(enc_sw(5'd0, 5'd3, 0));
    emit(enc_sw(5'd7, 5'd3, 4));
    expect_store(32'h404, jal_pc + 32'd4);
    jal_pc = next_pc();
    emit(enc_jal(5'd8, 12));
    emit(enc_sw(5'd7, 5'd3, 12));
    emit(enc_sw(5'd7, 5'd3, 16));
    emit(enc_sw(5'd8, 5'd3, 8));
    expect_store(32'h408, jal_pc + 32'd4);
    run_program();
endtask

task automatic test_back_pressure();
    rv_core_pkg::word_t vals [8];
    int                 n_stores;
    begin_test("straight run of stores");
    n_stores = 3 * QUEUE_DEPTH + 4;
    emit(enc_i(3'b000, 5'd3, 5'd0, 12'h500));
    for (int k = 0; k < 8; k++) begin
        vals[k] = $urandom();
        load_const(5'(8 + k), vals[k]);
    end
    for (int k = 0; k < n_stores; k++) begin
        emit(enc_sw(5'(8 + k % 8), 5'd3, k * 4));
        expect_store(32'h500 + 32'(k * 4), vals[k % 8]);
    end
    run_program();
endtask

`endif

// ==== tb/tb_rv_core.sv ====
// ========================================
// core testbench: clock, reset, memory
// model, store monitor, checks, watchdog
// and the directed test sequence
// ========================================

`timescale 1ns/10ps

module tb_rv_core;

    localparam int                 QUEUE_DEPTH = 4;
    localparam rv_core_pkg::word_t RESET_PC    = 32'h0000_0000;
    localparam int                 MEM_WORDS   = 1024;
    localparam int                 CLK_PERIOD  = 10;
    localparam int                 NUM_TESTS   = 5;
    localparam int                 TEST_CYCLES = 2000;
    localparam logic [31:0]        SEED        = 32'h619f_8591;

    logic               clk;
    logic               rst_i;
    logic               imem_req_o;
    rv_core_pkg::word_t imem_addr_o;
    rv_core_pkg::word_t imem_rdata_i;
    logic               dmem_we_o;
    rv_core_pkg::word_t dmem_addr_o;
    rv_core_pkg::word_t dmem_wdata_o;

    rv_core_pkg::word_t imem [MEM_WORDS];
    int unsigned        prog_len;
    rv_core_pkg::word_t exp_addr [$];
    rv_core_pkg::word_t exp_data [$];
    rv_core_pkg::word_t seen_addr [$];
    rv_core_pkg::word_t seen_data [$];

    rv_core_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .RESET_PC    (RESET_PC)
    ) dut_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .imem_rdata_i (imem_rdata_i),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // answers one cycle after the request
    always @(posedge clk) begin
        if (imem_req_o) begin
            imem_rdata_i <= imem[imem_addr_o[11:2]];
        end
    end

    // store monitor
    always @(posedge clk) begin
        if (!rst_i && dmem_we_o) begin
            seen_addr.push_back(dmem_addr_o);
            seen_data.push_back(dmem_wdata_o);
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input rv_core_pkg::word_t got,
                               input rv_core_pkg::word_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERROR: %s got 0x%08h expected 0x%08h",
                                        name, got, exp));
        end
    endtask

    function automatic rv_core_pkg::word_t next_pc();
        return RESET_PC + rv_core_pkg::word_t'(prog_len * 4);
    endfunction

    task automatic emit(input rv_core_pkg::word_t inst);
        rv_core_pkg::word_t pc;
        pc = next_pc();
        imem[pc[11:2]] = inst;
        prog_len++;
    endtask

    task automatic expect_store(input rv_core_pkg::word_t addr,
                                input rv_core_pkg::word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // reset goes high first so the old program cannot run into the new one
    task automatic begin_test(input string title);
        @(posedge clk);
        rst_i <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < MEM_WORDS; i++) begin
            // addi x0, x0, i
            imem[i] = {12'(i), 20'h0_0013};
        end
        prog_len = 0;
        exp_addr.delete();
        exp_data.delete();
        seen_addr.delete();
        seen_data.delete();
        $display("running: %s", title);
    endtask

    task automatic run_program();
        // park the core in a self loop
        emit(enc_jal(5'd0, 0));
        for (int i = 0; i < 15; i++) begin
            @(posedge clk);
            check_value("imem_req_o", 32'(imem_req_o), 32'h0);
            check_value("dmem_we_o", 32'(dmem_we_o), 32'h0);
        end
        rst_i <= 1'b0;
        // first cycle out of reset fetches from RESET_PC
        @(posedge clk);
        check_value("imem_req_o", 32'(imem_req_o), 32'h1);
        check_value("imem_addr_o", imem_addr_o, RESET_PC);
        while (seen_addr.size() < exp_addr.size()) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        if (seen_addr.size() != exp_addr.size()) begin
            stop_with_failure($sformatf("%0d stores seen although only %0d were expected",
                                        seen_addr.size(), exp_addr.size()));
        end else begin
            foreach (exp_addr[i]) begin
                check_value($sformatf("dmem_addr_o[%0d]", i), seen_addr[i], exp_addr[i]);
                check_value($sformatf("dmem_wdata_o[%0d]", i), seen_data[i], exp_data[i]);
            end
        end
    endtask

    `include "tb_programs.svh"

    initial begin
        void'($urandom(SEED));
        clk          = 1'b0;
        rst_i        = 1'b1;
        imem_rdata_i = rv_core_pkg::NOP_INST;
        prog_len     = 0;
        test_alu();
        test_x0_lui();
        test_branches();
        test_jal();
        test_back_pressure();
        $display("Test OK");
        $finish;
    end

    // budget of TEST_CYCLES per test
    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        stop_with_failure("watchdog expired before all tests finished");
    end

endmodule

// ==== sources.f ====
common/rv_core_pkg.sv
fetch/fetch_unit.sv
source/inst_queue.sv
execute/reg_file.sv
execute/exec_core.sv
source/rv_core_top.sv
+incdir+tb
tb/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv_core -f sources.f -o sim_tb_rv_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_rv_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Test OK$"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
